//--- hdl/sldu_cfg.svh
// Size settings of the vector slide unit
`ifndef SLDU_CFG_SVH
`define SLDU_CFG_SVH

// Bytes in one register-file word
`define SLDU_WORD_BYTES 16

// Bytes in one vector register
`define SLDU_VREG_BYTES 64

// Instruction queue entries
`define SLDU_INSN_DEPTH 2

// Result queue entries
`define SLDU_RESQ_DEPTH 2

// Instruction ID bits
`define SLDU_ID_W 3

// Register-file word address bits
`define SLDU_ADDR_W 8

`endif

//--- hdl/sldu_pkg.sv
// Shared element codes and word types of the vector slide unit
`include "sldu_cfg.svh"

package sldu_pkg;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Element width as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  // Slide direction
  typedef enum logic {
    SLIDE_DOWN = 1'b0,
    SLIDE_UP   = 1'b1
  } slide_op_e;

  ////////////////////////////////////////
  // Datapath words
  ////////////////////////////////////////

  // One register-file word and its byte enables
  typedef logic [8*`SLDU_WORD_BYTES-1:0] word_t;
  typedef logic [`SLDU_WORD_BYTES-1:0]   be_t;
  typedef logic [`SLDU_ADDR_W-1:0]       addr_t;

  // Element count up to 64 that also holds byte counts of one register
  typedef logic [$clog2(`SLDU_VREG_BYTES):0] vl_t;

  typedef logic [`SLDU_ID_W-1:0] id_t;

endpackage

//--- hdl/sldu_insn_queue.sv
// In-order instruction queue between the sequencer and the slide FSM
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_insn_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Request channel from the sequencer
  input  logic                req_valid_i,
  input  sldu_pkg::slide_op_e req_op_i,
  input  sldu_pkg::sew_e      req_sew_i,
  input  sldu_pkg::vl_t       req_vl_i,
  input  sldu_pkg::vl_t       req_stride_i,
  input  sldu_pkg::addr_t     req_vd_i,
  input  sldu_pkg::id_t       req_id_i,
  output logic                req_ready_o,
  // Head of the queue toward the slide FSM
  input  logic                issue_pop_i,
  output logic                issue_valid_o,
  output sldu_pkg::slide_op_e issue_op_o,
  output sldu_pkg::sew_e      issue_sew_o,
  output sldu_pkg::vl_t       issue_vl_o,
  output sldu_pkg::vl_t       issue_stride_o,
  output sldu_pkg::addr_t     issue_vd_o,
  output sldu_pkg::id_t       issue_id_o
);
  import sldu_pkg::*;

  localparam int unsigned DEPTH = `SLDU_INSN_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Entry storage with one array per field
  slide_op_e op_mem     [DEPTH];
  sew_e      sew_mem    [DEPTH];
  vl_t       vl_mem     [DEPTH];
  vl_t       stride_mem [DEPTH];
  addr_t     vd_mem     [DEPTH];
  id_t       id_mem     [DEPTH];

  logic [PTR_W-1:0] accept_ptr_q;
  logic [PTR_W-1:0] issue_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             accept;

  assign req_ready_o   = (cnt_q != (PTR_W+1)'(DEPTH));
  assign accept        = req_valid_i && req_ready_o;
  assign issue_valid_o = (cnt_q != '0);

  // Head entry is visible the cycle after it was written
  assign issue_op_o     = op_mem[issue_ptr_q];
  assign issue_sew_o    = sew_mem[issue_ptr_q];
  assign issue_vl_o     = vl_mem[issue_ptr_q];
  assign issue_stride_o = stride_mem[issue_ptr_q];
  assign issue_vd_o     = vd_mem[issue_ptr_q];
  assign issue_id_o     = id_mem[issue_ptr_q];

  // Pointers wrap at the queue depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      cnt_q        <= '0;
    end else begin
      if (accept) begin
        accept_ptr_q <= (accept_ptr_q == PTR_W'(DEPTH-1)) ? '0 : accept_ptr_q + 1'b1;
      end
      if (issue_pop_i) begin
        issue_ptr_q <= (issue_ptr_q == PTR_W'(DEPTH-1)) ? '0 : issue_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PTR_W+1)'(accept) - (PTR_W+1)'(issue_pop_i);
    end
  end

  // Stride is kept in bytes from here on
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_mem[accept_ptr_q]     <= req_op_i;
      sew_mem[accept_ptr_q]    <= req_sew_i;
      vl_mem[accept_ptr_q]     <= req_vl_i;
      stride_mem[accept_ptr_q] <= vl_t'(req_stride_i << req_sew_i);
      vd_mem[accept_ptr_q]     <= req_vd_i;
      id_mem[accept_ptr_q]     <= req_id_i;
    end
  end

  // The slide FSM only retires an instruction it was shown
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_pop_i |-> issue_valid_o
  );

endmodule

//--- hdl/sldu_byte_shifter.sv
// Byte aligner that picks one result word out of two neighbouring source words
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_byte_shifter (
  input  sldu_pkg::word_t                     prev_word_i,
  input  sldu_pkg::word_t                     cur_word_i,
  input  logic [$clog2(`SLDU_WORD_BYTES)-1:0] shift_i,
  input  sldu_pkg::slide_op_e                 dir_i,
  output sldu_pkg::word_t                     word_o
);
  import sldu_pkg::*;

  localparam int unsigned WB = `SLDU_WORD_BYTES;

  // Older word sits in the low half, so byte order follows the register
  logic [2*8*WB-1:0] pair;

  assign pair = {cur_word_i, prev_word_i};

  ////////////////////////////////////////
  // Byte select
  ////////////////////////////////////////

  always_comb begin
    for (int unsigned b = 0; b < WB; b++) begin
      if (dir_i == SLIDE_UP) begin
        // Slideup moves bytes toward higher addresses and the tail of prev fills the gap
        word_o[8*b +: 8] = pair[8*(b + WB - shift_i) +: 8];
      end else begin
        // Slidedown moves bytes toward lower addresses and the head of cur fills the top
        word_o[8*b +: 8] = pair[8*(b + shift_i) +: 8];
      end
    end
  end

endmodule

//--- hdl/sldu_slide_ctrl.sv
// Slide FSM that walks the source register word by word and emits shifted result words
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_slide_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Head of the instruction queue
  input  logic                                issue_valid_i,
  input  sldu_pkg::slide_op_e                 issue_op_i,
  input  sldu_pkg::sew_e                      issue_sew_i,
  input  sldu_pkg::vl_t                       issue_vl_i,
  input  sldu_pkg::vl_t                       issue_stride_i,
  input  sldu_pkg::addr_t                     issue_vd_i,
  input  sldu_pkg::id_t                       issue_id_i,
  output logic                                issue_pop_o,
  // Source operand stream
  input  logic                                op_valid_i,
  input  sldu_pkg::word_t                     op_data_i,
  output logic                                op_ready_o,
  // Byte shifter
  output logic [$clog2(`SLDU_WORD_BYTES)-1:0] shift_o,
  output sldu_pkg::word_t                     prev_word_o,
  output sldu_pkg::word_t                     cur_word_o,
  input  sldu_pkg::word_t                     shifted_i,
  // Result queue
  output logic                                push_o,
  output sldu_pkg::word_t                     push_data_o,
  output sldu_pkg::be_t                       push_be_o,
  output sldu_pkg::addr_t                     push_addr_o,
  input  logic                                result_full_i,
  input  logic                                result_empty_i,
  // Completion
  output logic                                done_o,
  output sldu_pkg::id_t                       done_id_o
);
  import sldu_pkg::*;

  localparam int unsigned WB     = `SLDU_WORD_BYTES;
  localparam int unsigned BOFF_W = $clog2(WB);
  localparam int unsigned WIDX_W = $clog2(`SLDU_VREG_BYTES / WB);

  typedef enum logic [1:0] {
    IDLE,
    PRIME,
    RUN,
    DRAIN
  } state_e;

  state_e state_q, state_d;

  // Output word index within the destination register
  logic [WIDX_W-1:0] out_idx_q;
  logic [WIDX_W-1:0] last_q;
  // Source words consumed, and how many to drop before the first result
  logic [WIDX_W:0]   src_idx_q;
  logic [WIDX_W:0]   skip_q;
  // Byte window that gets written
  vl_t               lo_q;
  vl_t               hi_q;
  id_t               id_q;
  word_t             prev_q;

  vl_t  vl_bytes;
  vl_t  vl_last;
  logic fire;
  logic last_push;

  assign vl_bytes = vl_t'(issue_vl_i << issue_sew_i);
  assign vl_last  = vl_bytes - vl_t'(1);

  ////////////////////////////////////////
  // Operand and result handshakes
  ////////////////////////////////////////

  // A full result queue stalls the operand stream too
  assign op_ready_o = ((state_q == PRIME) || (state_q == RUN)) && !result_full_i;
  assign fire       = op_valid_i && op_ready_o;

  // Slidedown drops leading source words until the window reaches word 0
  assign push_o      = fire && (src_idx_q >= skip_q);
  assign last_push   = push_o && (out_idx_q == last_q);
  assign issue_pop_o = last_push;

  // The first source word has nothing below it
  assign shift_o     = issue_stride_i[BOFF_W-1:0];
  assign prev_word_o = (state_q == PRIME) ? '0 : prev_q;
  assign cur_word_o  = op_data_i;

  assign push_data_o = shifted_i;
  assign push_addr_o = issue_vd_i + addr_t'(out_idx_q);
  assign done_id_o   = id_q;

  // Enables cover the absolute bytes in [lo, hi)
  always_comb begin
    vl_t pos;
    for (int unsigned i = 0; i < WB; i++) begin
      pos = vl_t'({out_idx_q, {BOFF_W{1'b0}}}) + vl_t'(i);
      push_be_o[i] = (pos >= lo_q) && (pos < hi_q);
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          state_d = PRIME;
        end
      end
      PRIME: begin
        // Slideup may finish on its very first word
        if (fire) begin
          state_d = last_push ? DRAIN : RUN;
        end
      end
      RUN: begin
        if (last_push) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (result_empty_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      out_idx_q <= '0;
      last_q    <= '0;
      src_idx_q <= '0;
      skip_q    <= '0;
      lo_q      <= '0;
      hi_q      <= '0;
      id_q      <= '0;
      done_o    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Done follows the cycle in which the last word left the result queue
      done_o  <= (state_q == DRAIN) && result_empty_i;
      if (state_q == IDLE && issue_valid_i) begin
        src_idx_q <= '0;
        id_q      <= issue_id_i;
        hi_q      <= vl_bytes;
        last_q    <= vl_last[BOFF_W +: WIDX_W];
        if (issue_op_i == SLIDE_UP) begin
          // Up starts writing at the word holding the stride
          out_idx_q <= issue_stride_i[BOFF_W +: WIDX_W];
          lo_q      <= issue_stride_i;
          skip_q    <= '0;
        end else begin
          out_idx_q <= '0;
          lo_q      <= '0;
          skip_q    <= issue_stride_i[BOFF_W +: WIDX_W+1] + 1'b1;
        end
      end
      if (fire) begin
        src_idx_q <= src_idx_q + 1'b1;
      end
      if (push_o) begin
        out_idx_q <= out_idx_q + 1'b1;
      end
    end
  end

  // Last consumed source word
  always_ff @(posedge clk_i) begin
    if (fire) begin
      prev_q <= op_data_i;
    end
  end

endmodule

//--- hdl/sldu_result_queue.sv
// Two-entry result FIFO between the slide FSM and the register-file write port
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_result_queue (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Writes from the slide FSM
  input  logic            push_i,
  input  sldu_pkg::word_t push_data_i,
  input  sldu_pkg::be_t   push_be_i,
  input  sldu_pkg::addr_t push_addr_i,
  output logic            full_o,
  output logic            empty_o,
  // Register-file write channel
  output logic            res_valid_o,
  output sldu_pkg::word_t res_data_o,
  output sldu_pkg::be_t   res_be_o,
  output sldu_pkg::addr_t res_addr_o,
  input  logic            res_ready_i
);
  import sldu_pkg::*;

  localparam int unsigned DEPTH = `SLDU_RESQ_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t data_mem [DEPTH];
  be_t   be_mem   [DEPTH];
  addr_t addr_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             pop;

  assign full_o      = (cnt_q == (PTR_W+1)'(DEPTH));
  assign empty_o     = (cnt_q == '0);
  assign res_valid_o = !empty_o;
  assign pop         = res_valid_o && res_ready_i;

  // Oldest entry faces the register file
  assign res_data_o = data_mem[rd_ptr_q];
  assign res_be_o   = be_mem[rd_ptr_q];
  assign res_addr_o = addr_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_mem[wr_ptr_q] <= push_data_i;
      be_mem[wr_ptr_q]   <= push_be_i;
      addr_mem[wr_ptr_q] <= push_addr_i;
    end
  end

  // Occupancy stays within the storage
  a_cnt_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cnt_q <= (PTR_W+1)'(DEPTH)
  );

  // The slide FSM never writes into a full queue
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  );

endmodule

//--- hdl/sldu_top.sv
// Slide unit top level wiring the instruction queue, slide FSM, byte shifter and result queue
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer requests
  input  logic                req_valid_i,
  input  sldu_pkg::slide_op_e req_op_i,
  input  sldu_pkg::sew_e      req_sew_i,
  input  sldu_pkg::vl_t       req_vl_i,
  input  sldu_pkg::vl_t       req_stride_i,
  input  sldu_pkg::addr_t     req_vd_i,
  input  sldu_pkg::id_t       req_id_i,
  output logic                req_ready_o,
  // Source operand stream
  input  logic                op_valid_i,
  input  sldu_pkg::word_t     op_data_i,
  output logic                op_ready_o,
  // Register-file writes
  output logic                res_valid_o,
  output sldu_pkg::word_t     res_data_o,
  output sldu_pkg::be_t       res_be_o,
  output sldu_pkg::addr_t     res_addr_o,
  input  logic                res_ready_i,
  // Completion
  output logic                done_o,
  output sldu_pkg::id_t       done_id_o
);
  import sldu_pkg::*;

  // Issue channel
  logic      issue_valid;
  logic      issue_pop;
  slide_op_e issue_op;
  sew_e      issue_sew;
  vl_t       issue_vl;
  vl_t       issue_stride;
  addr_t     issue_vd;
  id_t       issue_id;

  // Shifter operands
  logic [$clog2(`SLDU_WORD_BYTES)-1:0] shift;
  word_t prev_word;
  word_t cur_word;
  word_t shifted;

  // Result queue writes
  logic  push;
  word_t push_data;
  be_t   push_be;
  addr_t push_addr;
  logic  result_full;
  logic  result_empty;

  sldu_insn_queue insn_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_sew_i      (req_sew_i),
    .req_vl_i       (req_vl_i),
    .req_stride_i   (req_stride_i),
    .req_vd_i       (req_vd_i),
    .req_id_i       (req_id_i),
    .req_ready_o    (req_ready_o),
    .issue_pop_i    (issue_pop),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_sew_o    (issue_sew),
    .issue_vl_o     (issue_vl),
    .issue_stride_o (issue_stride),
    .issue_vd_o     (issue_vd),
    .issue_id_o     (issue_id)
  );

  sldu_slide_ctrl slide_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_op_i     (issue_op),
    .issue_sew_i    (issue_sew),
    .issue_vl_i     (issue_vl),
    .issue_stride_i (issue_stride),
    .issue_vd_i     (issue_vd),
    .issue_id_i     (issue_id),
    .issue_pop_o    (issue_pop),
    .op_valid_i     (op_valid_i),
    .op_data_i      (op_data_i),
    .op_ready_o     (op_ready_o),
    .shift_o        (shift),
    .prev_word_o    (prev_word),
    .cur_word_o     (cur_word),
    .shifted_i      (shifted),
    .push_o         (push),
    .push_data_o    (push_data),
    .push_be_o      (push_be),
    .push_addr_o    (push_addr),
    .result_full_i  (result_full),
    .result_empty_i (result_empty),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

  // Direction comes straight from the head instruction
  sldu_byte_shifter byte_shifter_i (
    .prev_word_i (prev_word),
    .cur_word_i  (cur_word),
    .shift_i     (shift),
    .dir_i       (issue_op),
    .word_o      (shifted)
  );

  sldu_result_queue result_queue_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_data_i (push_data),
    .push_be_i   (push_be),
    .push_addr_i (push_addr),
    .full_o      (result_full),
    .empty_o     (result_empty),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o),
    .res_be_o    (res_be_o),
    .res_addr_o  (res_addr_o),
    .res_ready_i (res_ready_i)
  );

endmodule

//--- tests/sldu_tb.sv
// Table-driven testbench of the slide unit against a byte-level reference model
`timescale 1ns/10ps
`include "sldu_cfg.svh"

module sldu_tb;
  import sldu_pkg::*;

  localparam int WB          = `SLDU_WORD_BYTES;
  localparam int VREG_BYTES  = `SLDU_VREG_BYTES;
  localparam int VREG_WORDS  = VREG_BYTES / WB;
  localparam int N_ENTRY     = 12;
  localparam int TIMEOUT_CYC = 2000;

  ////////////////////////////////////////
  // Stimulus table with the stride kept below vl
  ////////////////////////////////////////

  slide_op_e tbl_op [N_ENTRY] = '{SLIDE_UP, SLIDE_DOWN, SLIDE_UP, SLIDE_DOWN,
                                  SLIDE_UP, SLIDE_DOWN, SLIDE_UP, SLIDE_DOWN,
                                  SLIDE_UP, SLIDE_DOWN, SLIDE_UP, SLIDE_DOWN};
  sew_e tbl_sew [N_ENTRY]      = '{EW8, EW8, EW16, EW16, EW32, EW32,
                                  EW64, EW64, EW8, EW8, EW8, EW16};
  int   tbl_vl [N_ENTRY]       = '{64, 64, 32, 20, 16, 13, 8, 6, 37, 1, 64, 32};
  int   tbl_stride [N_ENTRY]   = '{5, 5, 9, 7, 4, 11, 3, 5, 36, 0, 47, 31};
  // Random result back-pressure
  bit   tbl_stall [N_ENTRY]    = '{0, 0, 0, 1, 0, 1, 1, 0, 1, 1, 1, 0};

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  slide_op_e req_op;
  sew_e      req_sew;
  vl_t       req_vl;
  vl_t       req_stride;
  addr_t     req_vd;
  id_t       req_id;
  logic      req_ready;
  logic      op_valid;
  word_t     op_data;
  logic      op_ready;
  logic      res_valid;
  word_t     res_data;
  be_t       res_be;
  addr_t     res_addr;
  logic      res_ready;
  logic      done;
  id_t       done_id;

  // Source register shared by every instruction
  logic [7:0] src_mem [VREG_BYTES];

  // Expected results in order
  addr_t exp_addr_q [$];
  word_t exp_data_q [$];
  be_t   exp_be_q   [$];
  id_t   exp_id_q   [$];
  int    exp_cnt_q  [$];

  int          err_cnt;
  int          check_cnt;
  int          done_cnt;
  int          words_seen;
  int          src_idx;
  int          test_no;
  int          pass_cnt;
  int          fail_cnt;
  bit          op_pending;
  bit          stall_en;
  bit          timed_out;

  sldu_top sldu_top_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_op_i     (req_op),
    .req_sew_i    (req_sew),
    .req_vl_i     (req_vl),
    .req_stride_i (req_stride),
    .req_vd_i     (req_vd),
    .req_id_i     (req_id),
    .req_ready_o  (req_ready),
    .op_valid_i   (op_valid),
    .op_data_i    (op_data),
    .op_ready_o   (op_ready),
    .res_valid_o  (res_valid),
    .res_data_o   (res_data),
    .res_be_o     (res_be),
    .res_addr_o   (res_addr),
    .res_ready_i  (res_ready),
    .done_o       (done),
    .done_id_o    (done_id)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Source word that reads as zero past the register end
  function automatic word_t src_word(input int idx);
    word_t w;
    int    b;
    w = '0;
    if (idx < VREG_WORDS) begin
      for (b = 0; b < WB; b++) begin
        w[8*b +: 8] = src_mem[idx*WB + b];
      end
    end
    return w;
  endfunction

  // Every destination word with at least one enabled byte in address order
  task automatic expect_slide(input int e, input addr_t vd, input id_t id);
    int    vl_b;
    int    st_b;
    int    abs_b;
    int    src_b;
    int    n_words;
    int    w;
    int    b;
    word_t data;
    be_t   be;
    vl_b    = tbl_vl[e] << tbl_sew[e];
    st_b    = tbl_stride[e] << tbl_sew[e];
    n_words = 0;
    for (w = 0; w < VREG_WORDS; w++) begin
      data = '0;
      be   = '0;
      for (b = 0; b < WB; b++) begin
        abs_b = w*WB + b;
        if (tbl_op[e] == SLIDE_UP) begin
          if (abs_b >= st_b && abs_b < vl_b) begin
            be[b]         = 1'b1;
            data[8*b +: 8] = src_mem[abs_b - st_b];
          end
        end else if (abs_b < vl_b) begin
          src_b          = abs_b + st_b;
          be[b]          = 1'b1;
          data[8*b +: 8] = (src_b < VREG_BYTES) ? src_mem[src_b] : 8'h00;
        end
      end
      if (be != '0) begin
        exp_addr_q.push_back(vd + addr_t'(w));
        exp_data_q.push_back(data);
        exp_be_q.push_back(be);
        n_words++;
      end
    end
    exp_id_q.push_back(id);
    exp_cnt_q.push_back(n_words);
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  // Data is compared on enabled bytes only
  task automatic check_result(input addr_t addr, input word_t data, input be_t be);
    addr_t e_addr;
    word_t e_data;
    be_t   e_be;
    word_t mask;
    int    b;
    check_cnt++;
    if (exp_data_q.size() == 0) begin
      $display("** Error @ %0t: unexpected result word at address 0x%0h", $time, addr);
      err_cnt++;
    end else begin
      e_addr = exp_addr_q.pop_front();
      e_data = exp_data_q.pop_front();
      e_be   = exp_be_q.pop_front();
      for (b = 0; b < WB; b++) begin
        mask[8*b +: 8] = {8{e_be[b]}};
      end
      if (addr != e_addr || be != e_be || (data & mask) != (e_data & mask)) begin
        $display("** Error @ %0t: result 0x%0h be %h data %h, expected 0x%0h be %h data %h",
                 $time, addr, be, data & mask, e_addr, e_be, e_data & mask);
        err_cnt++;
      end
      words_seen++;
    end
  endtask

  // Done must name the oldest instruction and follow all of its words
  task automatic check_done(input id_t id);
    id_t e_id;
    int  e_cnt;
    check_cnt++;
    done_cnt++;
    if (exp_id_q.size() == 0) begin
      $display("** Error @ %0t: unexpected done pulse with id %0d", $time, id);
      err_cnt++;
    end else begin
      e_id  = exp_id_q.pop_front();
      e_cnt = exp_cnt_q.pop_front();
      if (id != e_id || words_seen != e_cnt) begin
        $display("** Error @ %0t: done id %0d after %0d words, expected id %0d after %0d words",
                 $time, id, words_seen, e_id, e_cnt);
        err_cnt++;
      end
    end
    words_seen = 0;
  endtask

  task automatic check_idle_outputs();
    check_cnt++;
    if (req_ready !== 1'b1 || op_ready !== 1'b0 || res_valid !== 1'b0 || done !== 1'b0) begin
      $display("** Error @ %0t: after reset req_ready %b op_ready %b res_valid %b done %b",
               $time, req_ready, op_ready, res_valid, done);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Operand responder and result monitor
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      // Word offered last cycle was taken at the rising edge
      if (op_pending) begin
        src_idx++;
      end
      // Next instruction reads the register from word 0 again
      if (done) begin
        src_idx = 0;
      end
      op_valid   = 1'b1;
      op_data    = src_word(src_idx);
      op_pending = op_ready;
      res_ready  = stall_en ? ($urandom_range(2) != 0) : 1'b1;
      if (res_valid && res_ready) begin
        check_result(res_addr, res_data, res_be);
      end
      if (done) begin
        check_done(done_id);
      end
    end
  end

  ////////////////////////////////////////
  // Request driver and sequencing
  ////////////////////////////////////////

  // Returns on the rising edge that accepts the request
  task automatic send_request(input int e, input addr_t vd, input id_t id);
    int cyc;
    @(negedge clk);
    req_valid  = 1'b1;
    req_op     = tbl_op[e];
    req_sew    = tbl_sew[e];
    req_vl     = vl_t'(tbl_vl[e]);
    req_stride = vl_t'(tbl_stride[e]);
    req_vd     = vd;
    req_id     = id;
    cyc        = 0;
    while (!req_ready && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (!req_ready) begin
      $display("Timeout: request with id %0d was never accepted", id);
      timed_out = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic release_request();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_for_dones(input int target);
    int cyc;
    cyc = 0;
    while (done_cnt < target && cyc < TIMEOUT_CYC && !timed_out) begin
      @(posedge clk);
      cyc++;
    end
    if (done_cnt < target && !timed_out) begin
      $display("Timeout: only %0d of %0d done pulses arrived", done_cnt, target);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (err_cnt == err_start && !timed_out) begin
      pass_cnt++;
      $display("%s: PASS", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", name);
    end
  endtask

  task automatic run_single(input int e);
    int    err_start;
    int    target;
    addr_t vd;
    @(posedge clk);
    err_start = err_cnt;
    target    = done_cnt + 1;
    stall_en  = tbl_stall[e];
    vd        = addr_t'(test_no * 8);
    expect_slide(e, vd, id_t'(test_no));
    send_request(e, vd, id_t'(test_no));
    release_request();
    test_no++;
    wait_for_dones(target);
    report_test($sformatf("Entry %0d op %s sew %0d vl %0d stride %0d stall %0d", e,
                          tbl_op[e].name(), 8 << tbl_sew[e], tbl_vl[e], tbl_stride[e],
                          tbl_stall[e]), err_start);
  endtask

  // Second request follows on the very next cycle
  task automatic run_pair(input int e0, input int e1);
    int    err_start;
    int    target;
    addr_t vd0;
    addr_t vd1;
    @(posedge clk);
    err_start = err_cnt;
    target    = done_cnt + 2;
    stall_en  = tbl_stall[e0] | tbl_stall[e1];
    vd0       = addr_t'(test_no * 8);
    vd1       = addr_t'((test_no + 1) * 8);
    expect_slide(e0, vd0, id_t'(test_no));
    expect_slide(e1, vd1, id_t'(test_no + 1));
    send_request(e0, vd0, id_t'(test_no));
    send_request(e1, vd1, id_t'(test_no + 1));
    release_request();
    test_no += 2;
    wait_for_dones(target);
    report_test($sformatf("Back-to-back entries %0d and %0d", e0, e1), err_start);
  endtask

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = SLIDE_UP;
    req_sew    = EW8;
    req_vl     = '0;
    req_stride = '0;
    req_vd     = '0;
    req_id     = '0;
    op_valid   = 1'b0;
    op_data    = '0;
    res_ready  = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    done_cnt   = 0;
    words_seen = 0;
    src_idx    = 0;
    test_no    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    op_pending = 1'b0;
    stall_en   = 1'b0;
    timed_out  = 1'b0;
    void'($urandom(32'hadab));
    for (int i = 0; i < VREG_BYTES; i++) begin
      src_mem[i] = 8'($urandom);
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    // One instruction at a time
    for (int e = 0; e < N_ENTRY; e++) begin
      if (!timed_out) begin
        run_single(e);
      end
    end
    // Two in flight
    for (int e = 0; e + 1 < N_ENTRY; e += 2) begin
      if (!timed_out) begin
        run_pair(e, e + 1);
      end
    end

    if (!timed_out && exp_data_q.size() != 0) begin
      $display("** Error @ %0t: %0d expected result words never arrived", $time,
               exp_data_q.size());
      err_cnt++;
    end
    $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hdl
hdl/sldu_pkg.sv
hdl/sldu_insn_queue.sv
hdl/sldu_byte_shifter.sv
hdl/sldu_slide_ctrl.sv
hdl/sldu_result_queue.sv
hdl/sldu_top.sv
tests/sldu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the slide unit and its testbench with Verilator, run, then look for the pass line
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module sldu_tb \
  --Mdir obj_dir -o sldu_sim > compile.log 2>&1 && \
./obj_dir/sldu_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
